// ==== vlog.f ====
rtl/aprPkg.sv
rtl/specDecode.sv
rtl/aprFlagCell.sv
rtl/aprIntrMask.sv
rtl/aprDevice.sv
verification/tb_aprDevice.sv

// ==== Makefile ====
# Verilator build, run and lint for the APR device

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f vlog.f --top-module tb_aprDevice -Mdir obj_dir -o simv

run: build
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --top-module aprDevice \
		rtl/aprPkg.sv rtl/specDecode.sv rtl/aprFlagCell.sv \
		rtl/aprIntrMask.sv rtl/aprDevice.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_aprDevice.sv ====
// Self-checking testbench for the APR device; run through vlog.f with the Verilator Makefile
`default_nettype none

module tb_aprDevice
   import aprPkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////////////////////////
   // Run length and limits
   //////////////////////////////////////////////////

   localparam int RESET_CYCLES = 16;
   localparam int DIRECTED_CYCLES = 300;
   localparam int RANDOM_CYCLES = 3000;
   // Half again the whole run as margin
   localparam int TIMEOUT_CYCLES = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 3 / 2;
   localparam int SEED = 92;

   // Only the three constant ones after reset
   localparam aprFlagsT RESET_WORD = 14'h0007;

   // Reference state, enables in data path order 22 to 32
   typedef struct packed {
      logic [0:DPEN_W-1] en;
      logic [0:NUM_FLAGS-1] flags;
   } modelT;

   // DUT inputs
   logic clk = 1'b0;
   logic rst;
   logic clken;
   cromT crom;
   logic [0:DP_WIDTH-1] dp;
   logic [0:NUM_FLAGS-1] eventIntr;

   // DUT output
   aprFlagsT aprFlags;

   // Model and bookkeeping
   modelT refState = '0;
   modelT nextState;
   aprFlagsT expWord = RESET_WORD;
   logic checkOn = 1'b0;
   string testName = "reset";
   int cycleCount = 0;

   //////////////////////////////////////////////////
   // DUT
   //////////////////////////////////////////////////

   aprDevice u_aprDevice (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .crom      (crom),
      .dp        (dp),
      .eventIntr (eventIntr),
      .aprFlags  (aprFlags)
   );

   // 20 ns period
   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [13:0] expected,
      input logic [13:0] actual);
      if (actual !== expected)
      begin
         $display("error %s: expected %h actual %h", name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // Next state and flags word from the architectural rules
   function automatic aprFlagsT predictFlags(input modelT cur, input logic ck, input cromT cw,
      input logic [0:DP_WIDTH-1] d, input logic [0:NUM_FLAGS-1] ev, output modelT nxt);
      aprFlagsT w;
      logic active;
      nxt = cur;
      active = ck && cw.specEn;
      // Load enables takes bits 22 to 32
      if (active && (cw.specSel == SPEC_SEL_LOADAPR))
      begin
         nxt.en = d[22:32];
      end
      // Flag write, event forces a one
      if (active && (cw.specSel == SPEC_SEL_APRFLAGS))
      begin
         for (int i = 0; i < NUM_FLAGS; i++)
         begin
            nxt.flags[i] = ev[i] ? 1'b1 : d[24 + i];
         end
      end
      w.trapEn = nxt.en[0];
      w.pageEn = nxt.en[1];
      w.flags = nxt.flags;
      // Enabled flag or software request
      w.intReq = nxt.en[10];
      for (int i = 0; i < NUM_FLAGS; i++)
      begin
         if (nxt.flags[i] && nxt.en[2 + i])
         begin
            w.intReq = 1'b1;
         end
      end
      w.ones = 3'b111;
      return w;
   endfunction

   // Model steps on the same edge that the DUT samples
   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         refState = '0;
         expWord = RESET_WORD;
      end
      else
      begin
         expWord = predictFlags(refState, clken, crom, dp, eventIntr, nextState);
         refState = nextState;
      end
   end

   // Compare on the falling edge, outputs settled
   always @(negedge clk)
   begin
      if (checkOn)
      begin
         checkValue(testName, expWord, aprFlags);
      end
   end

   // Hang guard
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   function automatic logic [0:DP_WIDTH-1] randomDp();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[DP_WIDTH-1:0];
   endfunction

   function automatic logic [0:NUM_FLAGS-1] randomByte();
      logic [31:0] r;
      r = $urandom;
      return r[7:0];
   endfunction

   // Mostly APR codes, sometimes anything
   function automatic logic [SPEC_SEL_W-1:0] randomCode();
      logic [31:0] r;
      r = $urandom;
      if ((r % 3) == 0)
      begin
         return SPEC_SEL_LOADAPR;
      end
      else if ((r % 3) == 1)
      begin
         return SPEC_SEL_APRFLAGS;
      end
      return r[12:8];
   endfunction

   // Microword with random unrelated fields
   function automatic cromT makeWord(input logic en, input logic [SPEC_SEL_W-1:0] sel);
      cromT w;
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      w.specEn = en;
      w.specSel = sel;
      w.rest = r[CROM_REST_W-1:0];
      return w;
   endfunction

   // Enable fields placed in bits 22 to 32, noise elsewhere
   function automatic logic [0:DP_WIDTH-1] enableDp(input logic trap, input logic page,
      input logic [0:NUM_FLAGS-1] ie, input logic sw);
      logic [0:DP_WIDTH-1] d;
      d = randomDp();
      d[22] = trap;
      d[23] = page;
      d[24:31] = ie;
      d[32] = sw;
      return d;
   endfunction

   // Flag pattern in bits 24 to 31
   function automatic logic [0:DP_WIDTH-1] flagDp(input logic [0:NUM_FLAGS-1] f);
      logic [0:DP_WIDTH-1] d;
      d = randomDp();
      d[24:31] = f;
      return d;
   endfunction

   // One cycle of inputs, sampled at the next edge
   task automatic applyCycle(input logic ck, input logic en, input logic [SPEC_SEL_W-1:0] sel,
      input logic [0:DP_WIDTH-1] d, input logic [0:NUM_FLAGS-1] ev);
      @(posedge clk);
      clken <= ck;
      crom <= makeWord(en, sel);
      dp <= d;
      eventIntr <= ev;
   endtask

   // No special function, random events
   task automatic idleCycle(input logic [0:NUM_FLAGS-1] ev);
      applyCycle(1'b1, 1'b0, randomCode(), randomDp(), ev);
   endtask

   task automatic runRandom(input int cycles);
      logic ck;
      logic en;
      logic [0:NUM_FLAGS-1] ev;
      for (int n = 0; n < cycles; n++)
      begin
         ck = ($urandom % 4) != 0;
         en = ($urandom % 8) != 0;
         // Sparse events
         ev = (($urandom % 4) == 0) ? randomByte() : '0;
         applyCycle(ck, en, randomCode(), randomDp(), ev);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      logic [SPEC_SEL_W-1:0] code;
      void'($urandom(SEED));
      rst = 1'b1;
      clken = 1'b0;
      crom = '0;
      dp = '0;
      eventIntr = '0;

      // Reset
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      checkOn = 1'b1;
      @(negedge clk);
      checkValue("reset", RESET_WORD, aprFlags);

      // Enables, then flag patterns against them
      testName = "loadEnables";
      applyCycle(1'b1, 1'b1, SPEC_SEL_LOADAPR, enableDp(1'b0, 1'b0, 8'hA5, 1'b0), 8'h00);
      repeat (8) applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(randomByte()), 8'h00);
      // Software request alone
      applyCycle(1'b1, 1'b1, SPEC_SEL_LOADAPR, enableDp(1'b1, 1'b1, 8'h00, 1'b1), 8'h00);
      repeat (2) idleCycle(8'h00);
      applyCycle(1'b1, 1'b1, SPEC_SEL_LOADAPR, enableDp(1'b0, 1'b1, 8'hFF, 1'b0), 8'h00);
      repeat (8) applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(randomByte()), 8'h00);

      // Events override data only during a write
      testName = "flagEvents";
      applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(8'h00), 8'h81);
      repeat (6) idleCycle(randomByte());
      applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(8'hFF), 8'h00);
      applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(8'h00), 8'h24);
      repeat (6) idleCycle(randomByte());
      repeat (8) applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, randomDp(), randomByte());

      // Known state first so a stray write shows
      testName = "blocked";
      applyCycle(1'b1, 1'b1, SPEC_SEL_APRFLAGS, flagDp(8'h5A), 8'h00);
      applyCycle(1'b1, 1'b1, SPEC_SEL_LOADAPR, enableDp(1'b1, 1'b0, 8'h3C, 1'b0), 8'h00);
      // Clock enable low
      applyCycle(1'b0, 1'b1, SPEC_SEL_LOADAPR, enableDp(1'b0, 1'b1, 8'hC3, 1'b1), 8'hFF);
      applyCycle(1'b0, 1'b1, SPEC_SEL_APRFLAGS, enableDp(1'b0, 1'b1, 8'hC3, 1'b1), 8'hFF);
      // Special function disabled
      applyCycle(1'b1, 1'b0, SPEC_SEL_LOADAPR, enableDp(1'b0, 1'b1, 8'hC3, 1'b1), 8'hFF);
      applyCycle(1'b1, 1'b0, SPEC_SEL_APRFLAGS, enableDp(1'b0, 1'b1, 8'hC3, 1'b1), 8'hFF);
      // Every foreign select code
      for (int c = 0; c < 32; c++)
      begin
         code = c[4:0];
         if ((code != SPEC_SEL_LOADAPR) && (code != SPEC_SEL_APRFLAGS))
         begin
            applyCycle(1'b1, 1'b1, code, enableDp(1'b0, 1'b1, 8'hC3, 1'b1), 8'hFF);
         end
      end

      // Random mix
      testName = "random";
      runRandom(RANDOM_CYCLES);

      // Let the last write reach the compare
      repeat (2) idleCycle(8'h00);
      @(negedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/aprDevice.sv ====
// APR status and interrupt device top level; decoder, eight flag cells and the mask
`default_nettype none

module aprDevice
   import aprPkg::*;
(
   input  wire logic clk,
   input  wire logic rst,
   // Clock enable, freezes all state when low
   input  wire logic clken,
   // Control ROM word
   input  wire cromT crom,
   // Data path, bit 0 is MSB
   input  wire logic [0:DP_WIDTH-1] dp,
   // Hardware event lines, one per flag
   input  wire logic [0:NUM_FLAGS-1] eventIntr,
   // APR flags word, data path 22 to 35
   output aprFlagsT aprFlags
);

   //////////////////////////////////////////////////
   // Internal nets
   //////////////////////////////////////////////////

   // Decoded strobes
   aprStrobeT strobe;

   // Outputs of the flag cells
   logic [0:NUM_FLAGS-1] flagVec;

   // Enable-register slice of the data path
   logic [0:DPEN_W-1] dpEnable;

   // Bits 22 to 32
   assign dpEnable = dp[APR_LSB +: DPEN_W];

   //////////////////////////////////////////////////
   // Microcode decode
   //////////////////////////////////////////////////

   specDecode u_specDecode (
      .clken  (clken),
      .crom   (crom),
      .strobe (strobe)
   );

   //////////////////////////////////////////////////
   // Status flags
   //////////////////////////////////////////////////

   // Cell i holds data path bit 24 + i
   for (genvar i = 0; i < NUM_FLAGS; i++)
   begin : g_flag
      aprFlagCell u_aprFlagCell (
         .clk       (clk),
         .rst       (rst),
         .strobe    (strobe),
         .dpBit     (dp[FLAG_LSB + i]),
         .eventIntr (eventIntr[i]),
         .flag      (flagVec[i])
      );
   end

   //////////////////////////////////////////////////
   // Enables, mask and flags word
   //////////////////////////////////////////////////

   aprIntrMask u_aprIntrMask (
      .clk      (clk),
      .rst      (rst),
      .strobe   (strobe),
      .dpEnable (dpEnable),
      .flags    (flagVec),
      .aprFlags (aprFlags)
   );

endmodule

`default_nettype wire

// ==== rtl/aprIntrMask.sv ====
// APR enable register, interrupt request masking and assembly of the APR flags word
`default_nettype none

module aprIntrMask
   import aprPkg::*;
(
   input  wire logic clk,
   input  wire logic rst,
   // Strobes from the decoder
   input  wire aprStrobeT strobe,
   // Data path bits 22 to 32
   input  wire logic [0:DPEN_W-1] dpEnable,
   // Status flags, flag 24 first
   input  wire logic [0:NUM_FLAGS-1] flags,
   // Architectural flags word
   output aprFlagsT aprFlags
);

   //////////////////////////////////////////////////
   // Enable register layout
   //////////////////////////////////////////////////

   // Same bit order as data path 22 to 32
   typedef struct packed {
      // Bit 22
      logic trapEn;
      // Bit 23
      logic pageEn;
      // Bits 24 to 31, one per flag
      logic [0:NUM_FLAGS-1] intEn;
      // Bit 32
      logic swInt;
   } aprEnableT;

   // Enable register contents
   aprEnableT enableReg;

   // Flags that pass their enable
   logic [0:NUM_FLAGS-1] maskedFlags;

   // Combined interrupt request
   logic intReq;

   //////////////////////////////////////////////////
   // Enable register
   //////////////////////////////////////////////////

   // Loaded as a whole by the load-enables function
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         enableReg <= '0;
      end
      else if (strobe.loadApr)
      begin
         // Layout matches dpEnable bit for bit
         enableReg <= dpEnable;
      end
   end

   //////////////////////////////////////////////////
   // Interrupt mask
   //////////////////////////////////////////////////

   // Disabled flags are dropped here
   assign maskedFlags = flags & enableReg.intEn;

   // Any enabled flag, or the software request
   assign intReq = (|maskedFlags) | enableReg.swInt;

   //////////////////////////////////////////////////
   // Flags word
   //////////////////////////////////////////////////

   always_comb
   begin
      aprFlags.trapEn = enableReg.trapEn;
      aprFlags.pageEn = enableReg.pageEn;
      // Raw flags, not the masked ones
      aprFlags.flags = flags;
      aprFlags.intReq = intReq;
      // Architecturally always set
      aprFlags.ones = APR_ONES;
   end

endmodule

`default_nettype wire

// ==== rtl/aprFlagCell.sv ====
// One APR status flag bit; written from the data path, forced to one by its event line
`default_nettype none

module aprFlagCell
   import aprPkg::*;
(
   input  wire logic clk,
   input  wire logic rst,
   // Strobes from the decoder
   input  wire aprStrobeT strobe,
   // This flag's data path bit
   input  wire logic dpBit,
   // Hardware event for this flag
   input  wire logic eventIntr,
   // Stored flag
   output logic flag
);

   //////////////////////////////////////////////////
   // Flag register
   //////////////////////////////////////////////////

   // Only a flag write touches the bit
   // Event wins over the data bit during a write
   // Lets software clear a flag while hardware re-asserts it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flag <= 1'b0;
      end
      else if (strobe.writeFlags)
      begin
         if (eventIntr)
         begin
            // Pending condition sticks
            flag <= 1'b1;
         end
         else
         begin
            // Plain write from the data path
            flag <= dpBit;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/specDecode.sv ====
// Microword special-field decoder; turns the two APR special functions into strobes
`default_nettype none

module specDecode
   import aprPkg::*;
(
   // Clock enable level
   input  wire logic clken,
   // Current control ROM word
   input  wire cromT crom,
   // Decoded strobes
   output aprStrobeT strobe
);

   //////////////////////////////////////////////////
   // Qualification
   //////////////////////////////////////////////////

   // Special function active this cycle
   logic specActive;

   // No strobe unless the clock is enabled
   assign specActive = clken & crom.specEn;

   //////////////////////////////////////////////////
   // Select decode
   //////////////////////////////////////////////////

   // Only two codes matter to the APR
   // Everything else is somebody else's special function
   always_comb
   begin
      strobe = '0;
      if (specActive)
      begin
         case (crom.specSel)
            // Load trap, paging and interrupt enables
            SPEC_SEL_LOADAPR:
            begin
               strobe.loadApr = 1'b1;
            end
            // Write the status flags
            SPEC_SEL_APRFLAGS:
            begin
               strobe.writeFlags = 1'b1;
            end
            // Not an APR function
            default:
            begin
               strobe = '0;
            end
         endcase
      end
   end

   // Note that crom.rest is carried in the type but never looked at here.
   // The microsequencer and data path decode those fields themselves.

endmodule

`default_nettype wire

// ==== rtl/aprPkg.sv ====
// Shared widths, microcode codes and bus types for the APR device; import wherever needed
`default_nettype none

package aprPkg;

   //////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////

   // Full data path width
   // Bit 0 is the MSB in PDP-10 numbering
   localparam int DP_WIDTH = 36;

   // Status flags live in data path bits 24 to 31
   localparam int NUM_FLAGS = 8;
   localparam int FLAG_LSB = 24;

   // First data path bit of the APR flags word
   localparam int APR_LSB = 22;

   // Bits loaded by the enable register, 22 to 32
   localparam int DPEN_W = 11;

   // Constant ones at the bottom of the flags word
   localparam int ONES_W = 3;
   localparam logic [0:ONES_W-1] APR_ONES = '1;

   //////////////////////////////////////////////////
   // Microcode
   //////////////////////////////////////////////////

   // Control ROM word width
   localparam int CROM_WIDTH = 108;

   // Special function select field
   localparam int SPEC_SEL_W = 5;

   // Special function codes seen by this device
   localparam logic [SPEC_SEL_W-1:0] SPEC_SEL_LOADAPR = 5'o14;
   localparam logic [SPEC_SEL_W-1:0] SPEC_SEL_APRFLAGS = 5'o25;

   // Everything else in the microword
   localparam int CROM_REST_W = CROM_WIDTH - 1 - SPEC_SEL_W;

   //////////////////////////////////////////////////
   // Bus types
   //////////////////////////////////////////////////

   // Microword as seen by the APR
   typedef struct packed {
      // Special function enable
      logic specEn;
      // Special function select
      logic [SPEC_SEL_W-1:0] specSel;
      // Remaining fields, not decoded here
      logic [CROM_REST_W-1:0] rest;
   } cromT;

   // Decoded APR strobes
   // Both already qualified by the clock enable
   typedef struct packed {
      logic loadApr;
      logic writeFlags;
   } aprStrobeT;

   // APR flags word, data path bits 22 to 35
   typedef struct packed {
      // Bit 22
      logic trapEn;
      // Bit 23
      logic pageEn;
      // Bits 24 to 31, bit 24 leftmost
      logic [0:NUM_FLAGS-1] flags;
      // Bit 32
      logic intReq;
      // Bits 33 to 35
      logic [0:ONES_W-1] ones;
   } aprFlagsT;

endpackage

`default_nettype wire
